// File: logic/vertex_pkg.sv
// Vertex job controller shared definitions
// Field widths, array tags and the packed records passed between blocks

package vertex_pkg;

	localparam int VERTEX_W     = 32;
	localparam int LINE_VERTS   = 8;
	localparam int LINE_W       = LINE_VERTS * VERTEX_W;
	localparam int LINE_BYTES   = 32;
	localparam int ADDR_W       = 32;
	localparam int COUNT_W      = 32;
	localparam int ID_W         = 32;
	// Vertices carried in one line, 1 to LINE_VERTS
	localparam int LINE_COUNT_W = 4;

	typedef enum logic [1:0] {
		IN_DEGREE  = 2'd0,
		OUT_DEGREE = 2'd1,
		EDGES_IDX  = 2'd2
	} array_t;

	typedef struct packed {
		logic [COUNT_W-1:0] num_vertices;
		logic [ADDR_W-1:0]  in_degree_base;
		logic [ADDR_W-1:0]  out_degree_base;
		logic [ADDR_W-1:0]  edges_idx_base;
	} graph_cfg_t;

	typedef struct packed {
		logic [ADDR_W-1:0]       addr;
		array_t                  array;
		logic [LINE_COUNT_W-1:0] count;
	} read_cmd_t;

	// Vertex k sits in lane k, counted from the LSB
	typedef struct packed {
		array_t                  array;
		logic [LINE_COUNT_W-1:0] count;
		logic [LINE_W-1:0]       data;
	} read_line_t;

	typedef struct packed {
		logic [ID_W-1:0]     id;
		logic [VERTEX_W-1:0] in_degree;
		logic [VERTEX_W-1:0] out_degree;
		logic [VERTEX_W-1:0] edges_idx;
	} vertex_t;

endpackage

// File: logic/sync_fifo.sv
// Show-ahead synchronous FIFO for any packed payload type
// Oldest entry sits on data_out while valid; almost_full flags low headroom
`timescale 1ns/10ps

module sync_fifo #(
	parameter type T               = logic [7:0],
	parameter int  DEPTH           = 4,
	parameter int  ALMOST_FULL_GAP = 1
) (
	input  logic clock,
	input  logic rstn,
	input  logic push,
	input  T     data_in,
	input  logic pop,
	output logic valid,
	output T     data_out,
	output logic full,
	output logic almost_full,
	output logic empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T                 mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Storage, written on every push
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign empty       = (count == '0);
	assign full        = (count == CNT_W'(DEPTH));
	// Fewer than ALMOST_FULL_GAP free slots left
	assign almost_full = (int'(count) > DEPTH - ALMOST_FULL_GAP);
	assign valid       = !empty;
	assign data_out    = mem[rd_ptr];

	assert property (@(posedge clock) disable iff (!rstn) push |-> !full || pop)
		else $error("sync_fifo overflow");
	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
		else $error("sync_fifo underflow");

endmodule

// File: logic/vertex_cmd_gen.sv
// Vertex job command generator
// Splits the vertex range into line chunks and issues one read per array
`timescale 1ns/10ps

module vertex_cmd_gen import vertex_pkg::*; (
	input  logic       clock,
	input  logic       rstn,
	input  logic       start,
	input  graph_cfg_t cfg,
	output logic       cmd_push,
	output read_cmd_t  cmd,
	input  logic       cmd_empty,
	input  logic       room_low,
	input  logic       chunk_done,
	output logic       busy
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_WAIT_ROOM,
		S_ISSUE_IN,
		S_ISSUE_OUT,
		S_ISSUE_EDGES,
		S_WAIT_DONE
	} gen_state_t;

	gen_state_t              state;
	graph_cfg_t              cfg_q;
	logic [COUNT_W-1:0]      remaining;
	logic [ADDR_W-1:0]       offset;
	logic [LINE_COUNT_W-1:0] chunk_count;
	logic                    start_ok;

	assign start_ok    = start && (cfg.num_vertices != '0) && (state == S_IDLE);
	// Last chunk may be partial
	assign chunk_count = (remaining > COUNT_W'(LINE_VERTS)) ?
		LINE_COUNT_W'(LINE_VERTS) : remaining[LINE_COUNT_W-1:0];

	// Job configuration held for the whole job
	always_ff @(posedge clock) begin
		if (start_ok) begin
			cfg_q <= cfg;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Chunk sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= S_IDLE;
			remaining <= '0;
			offset    <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start_ok) begin
						remaining <= cfg.num_vertices;
						offset    <= '0;
						state     <= S_WAIT_ROOM;
					end
				end
				S_WAIT_ROOM: begin
					// Whole chunk must fit in both queues
					if (cmd_empty && !room_low) begin
						state <= S_ISSUE_IN;
					end
				end
				S_ISSUE_IN:  state <= S_ISSUE_OUT;
				S_ISSUE_OUT: state <= S_ISSUE_EDGES;
				S_ISSUE_EDGES: begin
					remaining <= remaining - COUNT_W'(chunk_count);
					offset    <= offset + ADDR_W'(LINE_BYTES);
					state     <= S_WAIT_DONE;
				end
				S_WAIT_DONE: begin
					if (chunk_done) begin
						state <= (remaining != '0) ? S_WAIT_ROOM : S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Reads go out as in-degree, out-degree, then edges index
	always_comb begin
		cmd_push  = 1'b0;
		cmd.array = IN_DEGREE;
		cmd.addr  = cfg_q.in_degree_base + offset;
		cmd.count = chunk_count;
		case (state)
			S_ISSUE_IN: begin
				cmd_push = 1'b1;
			end
			S_ISSUE_OUT: begin
				cmd_push  = 1'b1;
				cmd.array = OUT_DEGREE;
				cmd.addr  = cfg_q.out_degree_base + offset;
			end
			S_ISSUE_EDGES: begin
				cmd_push  = 1'b1;
				cmd.array = EDGES_IDX;
				cmd.addr  = cfg_q.edges_idx_base + offset;
			end
			default: ;
		endcase
	end

	assign busy = (state != S_IDLE);

	// Unpacker only finishes chunks this block started
	assert property (@(posedge clock) disable iff (!rstn) chunk_done |-> state != S_IDLE)
		else $error("chunk_done while generator idle");

endmodule

// File: logic/vertex_line_collect.sv
// Line collector for one chunk
// Holds the returned line of each array until the unpacker takes the set
`timescale 1ns/10ps

module vertex_line_collect import vertex_pkg::*; (
	input  logic       clock,
	input  logic       rstn,
	input  logic       rsp_valid,
	input  read_line_t rsp,
	input  logic       take,
	output logic       lines_ready,
	output read_line_t in_line,
	output read_line_t out_line,
	output read_line_t edges_line
);

	logic [2:0] flags;
	logic [2:0] rsp_hit;

	// One-hot of the array a response belongs to
	always_comb begin
		rsp_hit = 3'b000;
		case (rsp.array)
			IN_DEGREE:  rsp_hit = 3'b001;
			OUT_DEGREE: rsp_hit = 3'b010;
			EDGES_IDX:  rsp_hit = 3'b100;
			default:    rsp_hit = 3'b000;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rsp_valid) begin
			if (rsp_hit[0]) in_line    <= rsp;
			if (rsp_hit[1]) out_line   <= rsp;
			if (rsp_hit[2]) edges_line <= rsp;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			flags <= 3'b000;
		end else begin
			if (take) begin
				flags <= 3'b000;
			end
			if (rsp_valid) begin
				flags <= (take ? 3'b000 : flags) | rsp_hit;
			end
		end
	end

	assign lines_ready = &flags;

	// Each array returns one line per chunk
	assert property (@(posedge clock) disable iff (!rstn) rsp_valid |-> !(|(flags & rsp_hit)))
		else $error("duplicate response for array %0d", rsp.array);

endmodule

// File: logic/vertex_unpack.sv
// Vertex unpacker
// Shifts one lane per cycle out of the collected lines into numbered records
`timescale 1ns/10ps

module vertex_unpack import vertex_pkg::*; (
	input  logic       clock,
	input  logic       rstn,
	input  logic       lines_ready,
	input  read_line_t in_line,
	input  read_line_t out_line,
	input  read_line_t edges_line,
	output logic       take,
	output logic       vertex_push,
	output vertex_t    vertex,
	output logic       chunk_done
);

	logic [LINE_W-1:0]       in_sr;
	logic [LINE_W-1:0]       out_sr;
	logic [LINE_W-1:0]       edges_sr;
	logic [LINE_COUNT_W-1:0] left;
	logic [ID_W-1:0]         next_id;

	// Idle while no lanes are left
	assign take        = lines_ready && (left == '0);
	assign vertex_push = (left != '0);

	// Shift registers, loaded on take
	always_ff @(posedge clock) begin
		if (take) begin
			in_sr    <= in_line.data;
			out_sr   <= out_line.data;
			edges_sr <= edges_line.data;
		end else if (vertex_push) begin
			in_sr    <= in_sr >> VERTEX_W;
			out_sr   <= out_sr >> VERTEX_W;
			edges_sr <= edges_sr >> VERTEX_W;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			left       <= '0;
			next_id    <= '0;
			chunk_done <= 1'b0;
		end else begin
			chunk_done <= vertex_push && (left == LINE_COUNT_W'(1));
			if (take) begin
				left <= in_line.count;
			end else if (vertex_push) begin
				left    <= left - 1'b1;
				next_id <= next_id + 1'b1;
			end
		end
	end

	// Lowest lane of each register forms the record
	always_comb begin
		vertex.id         = next_id;
		vertex.in_degree  = in_sr[VERTEX_W-1:0];
		vertex.out_degree = out_sr[VERTEX_W-1:0];
		vertex.edges_idx  = edges_sr[VERTEX_W-1:0];
	end

	// All three reads of a chunk carry the same vertex count
	assert property (@(posedge clock) disable iff (!rstn)
		take |-> (in_line.count == out_line.count) && (in_line.count == edges_line.count)
			&& (in_line.count != '0))
		else $error("mismatched line counts in chunk");

endmodule

// File: logic/vertex_job_control.sv
// Vertex job controller top level
// Command generator, command queue, line collector, unpacker and vertex queue
`timescale 1ns/10ps

module vertex_job_control import vertex_pkg::*; #(
	parameter int CMD_DEPTH       = 4,
	parameter int VERTEX_DEPTH    = 16,
	parameter int ALMOST_FULL_GAP = LINE_VERTS
) (
	input  logic       clock,
	input  logic       rstn,
	input  logic       start,
	input  graph_cfg_t cfg,
	output logic       cmd_valid,
	input  logic       cmd_ready,
	output read_cmd_t  cmd,
	input  logic       rsp_valid,
	input  read_line_t rsp,
	output logic       vertex_valid,
	input  logic       vertex_ready,
	output vertex_t    vertex,
	output logic       busy
);

	logic       gen_push;
	read_cmd_t  gen_cmd;
	logic       cmd_empty;
	logic       room_low;
	logic       chunk_done;
	logic       lines_ready;
	logic       take;
	read_line_t in_line;
	read_line_t out_line;
	read_line_t edges_line;
	logic       unpack_push;
	vertex_t    unpack_vertex;

	////////////////////////////////////////////////////////////////////////////
	// Command side
	////////////////////////////////////////////////////////////////////////////

	vertex_cmd_gen i_vertex_cmd_gen (
		.clock     (clock),
		.rstn      (rstn),
		.start     (start),
		.cfg       (cfg),
		.cmd_push  (gen_push),
		.cmd       (gen_cmd),
		.cmd_empty (cmd_empty),
		.room_low  (room_low),
		.chunk_done(chunk_done),
		.busy      (busy)
	);

	sync_fifo #(
		.T              (read_cmd_t),
		.DEPTH          (CMD_DEPTH),
		.ALMOST_FULL_GAP(1)
	) i_cmd_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (gen_push),
		.data_in    (gen_cmd),
		.pop        (cmd_valid && cmd_ready),
		.valid      (cmd_valid),
		.data_out   (cmd),
		.full       (),
		.almost_full(),
		.empty      (cmd_empty)
	);

	////////////////////////////////////////////////////////////////////////////
	// Response and vertex side
	////////////////////////////////////////////////////////////////////////////

	vertex_line_collect i_vertex_line_collect (
		.clock      (clock),
		.rstn       (rstn),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.take       (take),
		.lines_ready(lines_ready),
		.in_line    (in_line),
		.out_line   (out_line),
		.edges_line (edges_line)
	);

	vertex_unpack i_vertex_unpack (
		.clock      (clock),
		.rstn       (rstn),
		.lines_ready(lines_ready),
		.in_line    (in_line),
		.out_line   (out_line),
		.edges_line (edges_line),
		.take       (take),
		.vertex_push(unpack_push),
		.vertex     (unpack_vertex),
		.chunk_done (chunk_done)
	);

	// Headroom of one full line keeps the unpacker from stalling
	sync_fifo #(
		.T              (vertex_t),
		.DEPTH          (VERTEX_DEPTH),
		.ALMOST_FULL_GAP(ALMOST_FULL_GAP)
	) i_vertex_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (unpack_push),
		.data_in    (unpack_vertex),
		.pop        (vertex_valid && vertex_ready),
		.valid      (vertex_valid),
		.data_out   (vertex),
		.full       (),
		.almost_full(room_low),
		.empty      ()
	);

endmodule

// File: tb/vertex_job_control_tb.sv
// Vertex job controller testbench
// Runs a table of jobs against a line memory model with random back-pressure
`timescale 1ns/10ps

module vertex_job_control_tb import vertex_pkg::*; ();

	localparam int          NUM_JOBS = 7;
	localparam logic [31:0] SEED     = 32'h2889_b79d;

	// Duty settings are eighths of cycles with ready high
	typedef struct packed {
		logic [31:0] num;
		logic [31:0] in_base;
		logic [31:0] out_base;
		logic [31:0] edges_base;
		logic [3:0]  cmd_duty;
		logic [3:0]  vtx_duty;
		logic        restart;
		logic [7:0]  exp_chunks;
	} job_row_t;

	job_row_t jobs [NUM_JOBS] = '{
		'{32'd20, 32'h0000_1000, 32'h0002_0000, 32'h0030_0040, 4'd8, 4'd8, 1'b0, 8'd3},
		'{32'd0,  32'h0000_5000, 32'h0000_6000, 32'h0000_7000, 4'd8, 4'd8, 1'b0, 8'd0},
		'{32'd8,  32'h0100_0000, 32'h0200_0000, 32'h0300_0000, 4'd3, 4'd5, 1'b0, 8'd1},
		'{32'd37, 32'h1000_0020, 32'h2000_0000, 32'h3000_0100, 4'd5, 4'd2, 1'b1, 8'd5},
		'{32'd3,  32'h0000_8000, 32'h0000_9000, 32'h0000_a000, 4'd8, 4'd1, 1'b0, 8'd1},
		'{32'd64, 32'h4000_0000, 32'h5000_0000, 32'h6000_0000, 4'd4, 4'd6, 1'b0, 8'd8},
		'{32'd1,  32'h7000_0000, 32'h7100_0000, 32'h7200_0000, 4'd2, 4'd8, 1'b1, 8'd1}
	};

	array_t tag_order [3] = '{IN_DEGREE, OUT_DEGREE, EDGES_IDX};

	logic       clock = 1'b0;
	logic       rstn;
	logic       start;
	graph_cfg_t cfg;
	logic       cmd_valid;
	logic       cmd_ready;
	read_cmd_t  cmd;
	logic       rsp_valid;
	read_line_t rsp;
	logic       vertex_valid;
	logic       vertex_ready;
	vertex_t    vertex;
	logic       busy;

	logic [31:0] lfsr_state;
	logic [31:0] cur_base [3];
	logic [31:0] cur_cmd_duty;
	logic [31:0] cur_vtx_duty;
	logic [31:0] expected_id;
	int          cur_n;
	int          cmd_seen;
	int          vtx_seen;
	int          errors;
	int          cycle_count;
	read_line_t  pend_line [$];
	int          pend_due [$];

	vertex_job_control #(
		.CMD_DEPTH      (4),
		.VERTEX_DEPTH   (16),
		.ALMOST_FULL_GAP(LINE_VERTS)
	) i_vertex_job_control (
		.clock       (clock),
		.rstn        (rstn),
		.start       (start),
		.cfg         (cfg),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd         (cmd),
		.rsp_valid   (rsp_valid),
		.rsp         (rsp),
		.vertex_valid(vertex_valid),
		.vertex_ready(vertex_ready),
		.vertex      (vertex),
		.busy        (busy)
	);

	always #2 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			bits       = {bits[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// Checks one transferring command and queues its line in the memory model
	task automatic accept_command();
		int          chunk;
		int          arr;
		int          left;
		logic [31:0] delay;
		read_line_t  line;
		if (cmd_seen >= 3 * ((cur_n + 7) / 8)) begin
			errors++;
			$display("Unexpected command at %0t for address %h", $time, cmd.addr);
		end else begin
			chunk = cmd_seen / 3;
			arr   = cmd_seen % 3;
			left  = cur_n - 8 * chunk;
			if (left > 8) begin
				left = 8;
			end
			check_value("cmd.array", 32'(cmd.array), 32'(tag_order[arr]));
			check_value("cmd.addr", cmd.addr, cur_base[arr] + 32'(32 * chunk));
			check_value("cmd.count", 32'(cmd.count), 32'(left));
		end
		cmd_seen++;
		line.array = cmd.array;
		line.count = cmd.count;
		for (int k = 0; k < LINE_VERTS; k++) begin
			line.data[VERTEX_W*k +: VERTEX_W] = cmd.addr + 32'(4 * k);
		end
		random_bits(3, delay);
		pend_line.push_back(line);
		pend_due.push_back(cycle_count + 1 + int'(delay));
	endtask

	task automatic accept_vertex();
		logic [31:0] offset;
		if (vtx_seen >= cur_n) begin
			errors++;
			$display("Unexpected vertex at %0t with id %0d", $time, vertex.id);
		end else begin
			offset = 32'(4 * vtx_seen);
			check_value("vertex.id", vertex.id, expected_id);
			check_value("vertex.in_degree", vertex.in_degree, cur_base[0] + offset);
			check_value("vertex.out_degree", vertex.out_degree, cur_base[1] + offset);
			check_value("vertex.edges_idx", vertex.edges_idx, cur_base[2] + offset);
		end
		vtx_seen++;
		expected_id++;
	endtask

	task automatic run_job(input job_row_t row);
		@(posedge clock);
		cur_n        = int'(row.num);
		cur_base[0]  = row.in_base;
		cur_base[1]  = row.out_base;
		cur_base[2]  = row.edges_base;
		cur_cmd_duty = 32'(row.cmd_duty);
		cur_vtx_duty = 32'(row.vtx_duty);
		cmd_seen     = 0;
		vtx_seen     = 0;
		@(negedge clock);
		cfg.num_vertices    = row.num;
		cfg.in_degree_base  = row.in_base;
		cfg.out_degree_base = row.out_base;
		cfg.edges_idx_base  = row.edges_base;
		start               = 1'b1;
		@(negedge clock);
		start = 1'b0;
		check_value("busy", 32'(busy), (row.num != 0) ? 32'd1 : 32'd0);
		if (row.num == 0) begin
			repeat (8) @(posedge clock);
		end
		// A second start mid-job must be ignored
		if (row.restart) begin
			@(negedge clock);
			cfg   = '{32'd16, 32'hdead_0000, 32'hdead_1000, 32'hdead_2000};
			start = 1'b1;
			@(negedge clock);
			start = 1'b0;
		end
		@(negedge clock);
		while (busy) begin
			@(negedge clock);
		end
		check_value("pending responses", 32'(pend_line.size()), 32'd0);
		check_value("command count", 32'(cmd_seen), 32'(3 * int'(row.exp_chunks)));
		while (vtx_seen < cur_n) begin
			@(posedge clock);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory model and ready generation
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] draw;
		lfsr_state   = SEED;
		cycle_count  = 0;
		cmd_ready    = 1'b0;
		vertex_ready = 1'b0;
		rsp_valid    = 1'b0;
		rsp          = '0;
		forever begin
			@(negedge clock);
			cycle_count++;
			// Responses go back in order at most one per cycle
			rsp_valid = 1'b0;
			if (pend_line.size() > 0 && pend_due[0] <= cycle_count) begin
				rsp       = pend_line.pop_front();
				rsp_valid = 1'b1;
				void'(pend_due.pop_front());
			end
			random_bits(3, draw);
			cmd_ready = (draw < cur_cmd_duty);
			if (rstn && cmd_valid && cmd_ready) begin
				accept_command();
			end
			random_bits(3, draw);
			vertex_ready = (draw < cur_vtx_duty);
			if (rstn && vertex_valid && vertex_ready) begin
				accept_vertex();
			end
		end
	end

	initial begin
		int limit;
		limit = 500;
		for (int j = 0; j < NUM_JOBS; j++) begin
			limit += 60 * int'(jobs[j].num);
		end
		repeat (limit) @(posedge clock);
		$display("Timeout: the jobs did not finish within %0d cycles", limit);
		$display(">>> FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Job sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		errors       = 0;
		expected_id  = '0;
		cur_n        = 0;
		cur_cmd_duty = 32'd8;
		cur_vtx_duty = 32'd8;
		cur_base     = '{32'd0, 32'd0, 32'd0};
		rstn         = 1'b0;
		start        = 1'b0;
		cfg          = '0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		check_value("busy", 32'(busy), 32'd0);
		check_value("cmd_valid", 32'(cmd_valid), 32'd0);
		check_value("vertex_valid", 32'(vertex_valid), 32'd0);
		for (int j = 0; j < NUM_JOBS; j++) begin
			run_job(jobs[j]);
		end
		// Nothing left over once every job is done
		repeat (20) @(posedge clock);
		@(negedge clock);
		check_value("cmd_valid", 32'(cmd_valid), 32'd0);
		check_value("vertex_valid", 32'(vertex_valid), 32'd0);
		check_value("busy", 32'(busy), 32'd0);
		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: build.f
logic/vertex_pkg.sv
logic/sync_fifo.sv
logic/vertex_cmd_gen.sv
logic/vertex_line_collect.sv
logic/vertex_unpack.sv
logic/vertex_job_control.sv
tb/vertex_job_control_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the vertex job controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=vertex_job_control_sim

verilator --binary --timing --assert -j 0 \
	--top-module vertex_job_control_tb \
	-f build.f -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

exit 0
